// ==== tftPkg.sv ====
// ILI9341 display driver package: widths, register map, controller states and bundles
package tftPkg;

	// sizes
	localparam int INIT_SEQ_LEN = 52; // words in the init rom image
	localparam int FB_DEPTH = 256; // pixels in the frame buffer
	localparam int CLK_MHZ = 12; // intended system clock, sets the delay defaults

	typedef logic [8:0] spiWord_t; // bit 8 dc flag, 7..0 byte
	typedef logic [15:0] pixel_t; // rgb565
	typedef logic [7:0] fbAddr_t;
	typedef logic [5:0] initAddr_t;
	typedef logic [23:0] delayTicks_t; // clock cycles
	typedef logic [2:0] regAddr_t;

	// power-up timing defaults, datasheet minimums
	localparam delayTicks_t DEF_RESET_TICKS = delayTicks_t'(CLK_MHZ * 10); // 10 us
	localparam delayTicks_t DEF_POWERUP_TICKS = delayTicks_t'(CLK_MHZ * 120000); // 120 ms
	localparam delayTicks_t DEF_SLEEP_TICKS = delayTicks_t'(CLK_MHZ * 5000); // 5 ms
	localparam delayTicks_t DEF_SETTLE_TICKS = delayTicks_t'(CLK_MHZ * 10000); // 10 ms

	localparam logic [7:0] CMD_SLEEP_OUT = 8'h11;

	// config register map
	localparam regAddr_t REG_ENABLE = 3'd0;
	localparam regAddr_t REG_RESET_TICKS = 3'd1;
	localparam regAddr_t REG_POWERUP_TICKS = 3'd2;
	localparam regAddr_t REG_SLEEP_TICKS = 3'd3;
	localparam regAddr_t REG_SETTLE_TICKS = 3'd4;

	typedef enum logic [2:0] {START, HOLD_RESET, WAIT_POWERUP, SEND_INIT, STREAM} tftState_t;

	typedef struct packed {
		logic strobe; // one cycle per write
		regAddr_t addr;
		delayTicks_t data; // enable uses bit 0 only
	} hostWrite_t;

	typedef struct packed {
		logic strobe;
		fbAddr_t addr;
		pixel_t data;
	} fbWrite_t;

	typedef struct packed {
		logic enable;
		delayTicks_t resetTicks;
		delayTicks_t powerupTicks;
		delayTicks_t sleepTicks;
		delayTicks_t settleTicks;
	} tftConfig_t;

	typedef struct packed {
		logic sck;
		logic sdi;
		logic dc;
		logic cs;
		logic panelReset; // active low at the panel
	} tftPins_t;

endpackage

// ==== tftInitRom.sv ====
`timescale 1ns/1ps
// ILI9341 init sequence ROM: power, gamma and pixel-format words with a registered read
module tftInitRom import tftPkg::*; (
	input logic clk,
	input initAddr_t addr,
	output spiWord_t word
);

	// full index range so the end-of-sequence address stays in bounds
	localparam int ROM_DEPTH = 2 ** $bits(initAddr_t);

	spiWord_t rom [ROM_DEPTH];

	// image holds {dc, byte} per line in hex
	initial begin
		$readmemh("tft.mem", rom, 0, INIT_SEQ_LEN - 1);
	end

	// one cycle read latency, controller accounts for it
	always_ff @(posedge clk) begin
		word <= rom[addr];
	end

endmodule

// ==== tftSpiSerializer.sv ====
`timescale 1ns/1ps
// ILI9341 SPI serializer: shifts one 9-bit word out msb first, framed by cs
module tftSpiSerializer import tftPkg::*; (
	input logic clk,
	input logic reset,
	input spiWord_t word, // latched on send
	input logic send, // one-cycle strobe, only while idle
	output logic sck,
	output logic sdi,
	output logic dc,
	output logic cs,
	output logic idle
);

	logic [7:0] shiftReg; // msb sits on sdi
	logic [3:0] bitCnt; // bits already finished in this word
	logic phase; // 0 sck low half, 1 sck high half
	logic busy;

	assign sdi = shiftReg[7];
	assign idle = !busy; // registered, so idle drops the cycle after send

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cs <= 1'b1;
			sck <= 1'b0;
			dc <= 1'b0;
			phase <= 1'b0;
			bitCnt <= '0;
			shiftReg <= '0;
		end else if (!busy) begin
			if (send) begin
				shiftReg <= word[7:0];
				dc <= word[8]; // held for the whole word
				cs <= 1'b0; // low from the next cycle
				busy <= 1'b1;
				bitCnt <= '0;
				phase <= 1'b0;
			end
		end else if (!phase) begin
			sck <= 1'b1; // panel samples on this edge
			phase <= 1'b1;
		end else begin
			sck <= 1'b0;
			phase <= 1'b0;
			if (bitCnt == 4'd7) begin
				// last bit done, close the frame
				cs <= 1'b1;
				busy <= 1'b0;
			end else begin
				bitCnt <= bitCnt + 4'd1;
				shiftReg <= {shiftReg[6:0], 1'b0}; // next bit while sck low
			end
		end
	end

endmodule

// ==== tftFrameBuffer.sv ====
`timescale 1ns/1ps
// pixel frame buffer: host write port and registered read port for the stream
module tftFrameBuffer import tftPkg::*; (
	input logic clk,
	input fbWrite_t hostFb, // single-cycle writes, never stalled
	input fbAddr_t rdAddr, // from the controller
	output pixel_t rdPixel // valid one cycle after rdAddr
);

	pixel_t mem [FB_DEPTH];

	// host port
	// repaint can happen while the stream is running
	always_ff @(posedge clk) begin
		if (hostFb.strobe) begin
			mem[hostFb.addr] <= hostFb.data;
		end
	end

	// stream port
	// read before write on a same-address collision,
	// new value shows on the following read
	always_ff @(posedge clk) begin
		rdPixel <= mem[rdAddr];
	end

endmodule

// ==== tftConfigRegs.sv ====
`timescale 1ns/1ps
// display config registers: enable bit and the four power-up delay counts
module tftConfigRegs import tftPkg::*; (
	input logic clk,
	input logic reset,
	input hostWrite_t hostReg, // strobed, no back-pressure
	output tftConfig_t cfg // straight from the flops
);

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg.enable <= 1'b0; // panel stays untouched until the host says go
			cfg.resetTicks <= DEF_RESET_TICKS;
			cfg.powerupTicks <= DEF_POWERUP_TICKS;
			cfg.sleepTicks <= DEF_SLEEP_TICKS;
			cfg.settleTicks <= DEF_SETTLE_TICKS;
		end else if (hostReg.strobe) begin
			// address decode
			case (hostReg.addr)
				REG_ENABLE: begin
					cfg.enable <= hostReg.data[0];
				end
				REG_RESET_TICKS: begin
					cfg.resetTicks <= hostReg.data; // panel reset pulse width
				end
				REG_POWERUP_TICKS: begin
					cfg.powerupTicks <= hostReg.data;
				end
				REG_SLEEP_TICKS: begin
					cfg.sleepTicks <= hostReg.data; // after sleep-out
				end
				REG_SETTLE_TICKS: begin
					cfg.settleTicks <= hostReg.data; // before first pixel
				end
				default: begin
					// unmapped address, write dropped
				end
			endcase
		end
	end

endmodule

// ==== tftController.sv ====
`timescale 1ns/1ps
// ILI9341 controller FSM: panel reset, power-up, init words, then endless pixel stream
module tftController import tftPkg::*; (
	input logic clk,
	input logic reset,
	input tftConfig_t cfg,
	output initAddr_t romAddr, // doubles as the init word counter
	input spiWord_t romWord, // one cycle behind romAddr
	output fbAddr_t fbAddr,
	input pixel_t fbPixel, // one cycle behind fbAddr
	output spiWord_t spiWord,
	output logic spiSend,
	input logic spiIdle,
	output logic panelReset // active low
);

	tftState_t state;
	delayTicks_t remainingTicks; // countdown before the next step
	logic lowByte; // next pixel byte is the low one
	logic [7:0] pixelByte;
	logic lastPixel;

	// high byte first, then low byte of the same pixel
	assign pixelByte = lowByte ? fbPixel[7:0] : fbPixel[15:8];
	assign lastPixel = (fbAddr == fbAddr_t'(FB_DEPTH - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= START;
			remainingTicks <= '0;
			panelReset <= 1'b1;
			spiSend <= 1'b0;
			romAddr <= '0;
			fbAddr <= '0;
			lowByte <= 1'b0;
		end else begin
			spiSend <= 1'b0; // strobe lasts one cycle

			if (remainingTicks != '0) begin
				remainingTicks <= remainingTicks - 1'b1;
			end else if (spiIdle && !spiSend) begin
				// idle lags send by a cycle, hence the spiSend check
				case (state)
					START: begin
						if (cfg.enable) begin
							panelReset <= 1'b0; // assert panel reset
							remainingTicks <= cfg.resetTicks;
							state <= HOLD_RESET;
						end
					end

					HOLD_RESET: begin
						panelReset <= 1'b1; // release, panel boots
						remainingTicks <= cfg.powerupTicks;
						state <= WAIT_POWERUP;
					end

					WAIT_POWERUP: begin
						// sleep-out is a command, dc low
						spiWord <= {1'b0, CMD_SLEEP_OUT};
						spiSend <= 1'b1;
						remainingTicks <= cfg.sleepTicks;
						state <= SEND_INIT;
					end

					SEND_INIT: begin
						if (romAddr < initAddr_t'(INIT_SEQ_LEN)) begin
							// romWord settled long ago, serializer takes 18 cycles
							spiWord <= romWord;
							spiSend <= 1'b1;
							romAddr <= romAddr + 1'b1;
						end else begin
							remainingTicks <= cfg.settleTicks;
							state <= STREAM;
						end
					end

					STREAM: begin
						spiWord <= {1'b1, pixelByte}; // pixel data, dc high
						spiSend <= 1'b1;
						lowByte <= !lowByte;
						if (lowByte) begin
							// pixel done, fetch the next one
							fbAddr <= lastPixel ? '0 : fbAddr + 1'b1;
						end
					end

					default: begin
						state <= START;
					end
				endcase
			end
		end
	end

endmodule

// ==== tftSubsystem.sv ====
`timescale 1ns/1ps
// ILI9341 display subsystem top: config, controller, init rom, frame buffer and SPI
module tftSubsystem import tftPkg::*; (
	input logic clk,
	input logic reset,
	input hostWrite_t hostReg, // config writes
	input fbWrite_t hostFb, // pixel writes
	output tftPins_t pins // to the panel connector
);

	tftConfig_t cfg;
	initAddr_t romAddr;
	spiWord_t romWord;
	fbAddr_t fbAddr;
	pixel_t fbPixel;
	spiWord_t spiWord;
	logic spiSend;
	logic spiIdle;
	logic sck, sdi, dc, cs; // serializer pins
	logic panelReset; // controller pin

	tftConfigRegs configRegs0 (
		.clk(clk),
		.reset(reset),
		.hostReg(hostReg),
		.cfg(cfg)
	);

	tftController controller0 (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.romAddr(romAddr),
		.romWord(romWord),
		.fbAddr(fbAddr),
		.fbPixel(fbPixel),
		.spiWord(spiWord),
		.spiSend(spiSend),
		.spiIdle(spiIdle),
		.panelReset(panelReset)
	);

	tftInitRom initRom0 (.clk(clk), .addr(romAddr), .word(romWord));

	tftFrameBuffer frameBuffer0 (
		.clk(clk),
		.hostFb(hostFb),
		.rdAddr(fbAddr),
		.rdPixel(fbPixel)
	);

	tftSpiSerializer spi0 (
		.clk(clk),
		.reset(reset),
		.word(spiWord),
		.send(spiSend),
		.sck(sck),
		.sdi(sdi),
		.dc(dc),
		.cs(cs),
		.idle(spiIdle)
	);

	assign pins = '{sck: sck, sdi: sdi, dc: dc, cs: cs, panelReset: panelReset};

endmodule

// ==== tftClockGen.sv ====
`timescale 1ns/1ps
// testbench clock and reset source: 8 ns clock, reset held for the first 3 cycles
module tftClockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		reset = 1'b1; // high from time zero
		repeat (3) @(posedge clk);
		#1 reset = 1'b0; // released just off the third edge
	end

	always #4 clk = !clk; // half of the 8 ns period

endmodule

// ==== tbTftSubsystem.sv ====
`timescale 1ns/1ps
// tft subsystem testbench: directed tests of panel reset, init words and the pixel stream
module tbTftSubsystem import tftPkg::*; ();

	localparam int RESET_T = 20; // shortened delays, in clock cycles
	localparam int POWERUP_T = 50;
	localparam int SLEEP_T = 30;
	localparam int SETTLE_T = 40;
	localparam int IDLE_CYCLES = 200;
	localparam int LIVE_ADDR = 200; // repainted while the stream is at the start of a pass
	localparam int WORD_CYCLES = 20; // serializer needs 18 per word
	localparam int TIMEOUT_CYCLES = IDLE_CYCLES + 2 * FB_DEPTH + 20
		+ RESET_T + POWERUP_T + SLEEP_T + SETTLE_T
		+ (1 + INIT_SEQ_LEN + 2 * FB_DEPTH * 2) * WORD_CYCLES + 1000;

	logic clk;
	logic reset;
	hostWrite_t hostReg;
	fbWrite_t hostFb;
	tftPins_t pins;

	spiWord_t initImage [INIT_SEQ_LEN]; // expected init words
	pixel_t pixels [FB_DEPTH]; // model of the frame buffer contents
	spiWord_t rxWords [$]; // words seen on the SPI pins
	int seed = 32'hde80;
	int errorCount = 0;
	int cycleCount = 0;
	int wordsSeen = 0;
	int framingErrors = 0; // words without exactly 8 sck pulses
	int dcErrors = 0;

	// monitor state
	logic prevSck = 1'b0;
	logic prevCs = 1'b1;
	logic wordDc = 1'b0;
	logic [7:0] shiftByte = '0;
	int pulseCount = 0;

	tftClockGen clockGen0 (.clk(clk), .reset(reset));

	tftSubsystem dut0 (
		.clk(clk),
		.reset(reset),
		.hostReg(hostReg),
		.hostFb(hostFb),
		.pins(pins)
	);

	// SPI monitor, sampled mid-cycle when the pins are settled
	always @(negedge clk) begin
		if (prevCs && !pins.cs) begin
			shiftByte = '0; // frame opens
			pulseCount = 0;
			wordDc = pins.dc;
		end
		if (!prevSck && pins.sck && !pins.cs) begin
			shiftByte = {shiftByte[6:0], pins.sdi}; // msb first
			pulseCount++;
			if (pins.dc !== wordDc) dcErrors++;
		end
		if (!prevCs && pins.cs) begin
			if (pulseCount != 8) framingErrors++;
			rxWords.push_back({wordDc, shiftByte});
			wordsSeen++;
		end
		prevSck = pins.sck;
		prevCs = pins.cs;
	end

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error: %s expected 0x%h actual 0x%h", what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic writeReg(input regAddr_t addr, input delayTicks_t data);
		@(posedge clk);
		#1;
		hostReg.addr = addr;
		hostReg.data = data;
		hostReg.strobe = 1'b1;
		@(posedge clk);
		#1 hostReg.strobe = 1'b0; // single-cycle strobe
	endtask

	task automatic writePixel(input fbAddr_t addr, input pixel_t data);
		@(posedge clk);
		#1;
		hostFb.addr = addr;
		hostFb.data = data;
		hostFb.strobe = 1'b1;
		@(posedge clk);
		#1 hostFb.strobe = 1'b0;
	endtask

	// blocks until the monitor has a word, global timeout guards it
	task automatic expectWord(input string what, input spiWord_t expected);
		spiWord_t got;
		while (rxWords.size() == 0) @(posedge clk);
		got = rxWords.pop_front();
		checkValue(what, 32'(expected), 32'(got));
	endtask

	task automatic expectPixel(input int addr);
		expectWord($sformatf("pixel %0d high byte", addr), {1'b1, pixels[addr][15:8]});
		expectWord($sformatf("pixel %0d low byte", addr), {1'b1, pixels[addr][7:0]});
	endtask

	task automatic checkIdleAfterReset();
		int csLow = 0;
		int panelLow = 0;
		@(negedge clk);
		checkValue("sck after reset", 32'(1'b0), 32'(pins.sck));
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			if (pins.cs !== 1'b1) csLow++;
			if (pins.panelReset !== 1'b1) panelLow++;
		end
		checkValue("cs low cycles while disabled", 0, csLow);
		checkValue("panelReset low cycles while disabled", 0, panelLow);
		checkValue("words while disabled", 0, wordsSeen);
	endtask

	task automatic fillFrameBuffer();
		for (int i = 0; i < FB_DEPTH; i++) begin
			pixels[i] = pixel_t'($random(seed));
			writePixel(fbAddr_t'(i), pixels[i]);
		end
	endtask

	task automatic checkPanelReset();
		int lowCycles = 0;
		writeReg(REG_RESET_TICKS, delayTicks_t'(RESET_T));
		writeReg(REG_POWERUP_TICKS, delayTicks_t'(POWERUP_T));
		writeReg(REG_SLEEP_TICKS, delayTicks_t'(SLEEP_T));
		writeReg(REG_SETTLE_TICKS, delayTicks_t'(SETTLE_T));
		writeReg(REG_ENABLE, 24'd1);
		while (pins.panelReset === 1'b1) @(negedge clk);
		while (pins.panelReset === 1'b0) begin
			lowCycles++;
			@(negedge clk);
		end
		checkValue("panelReset held for resetTicks", 32'd1, 32'(lowCycles >= RESET_T));
		checkValue("words before panelReset release", 0, wordsSeen);
		checkValue("cs at panelReset release", 32'(1'b1), 32'(pins.cs));
	endtask

	task automatic checkInitOrder();
		expectWord("sleep-out command", {1'b0, 8'h11});
		for (int i = 0; i < INIT_SEQ_LEN; i++) begin
			expectWord($sformatf("init word %0d", i), initImage[i]);
		end
	endtask

	task automatic checkPixelStream();
		for (int a = 0; a < FB_DEPTH; a++) begin
			expectPixel(a);
		end
		expectPixel(0); // wrapped back to the first pixel
	endtask

	task automatic checkLiveUpdate();
		pixel_t newPixel;
		newPixel = ~pixels[LIVE_ADDR]; // always differs from the old value
		writePixel(fbAddr_t'(LIVE_ADDR), newPixel);
		pixels[LIVE_ADDR] = newPixel;
		for (int a = 1; a <= LIVE_ADDR; a++) begin
			expectPixel(a);
		end
	endtask

	task automatic checkWordFraming();
		checkValue("words with a wrong sck pulse count", 0, framingErrors);
		checkValue("dc changes inside a word", 0, dcErrors);
	endtask

	// run limit from the test length
	initial begin
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		hostReg = '0;
		hostFb = '0;
		$readmemh("tft.mem", initImage);
		while (reset !== 1'b0) @(posedge clk);
		checkIdleAfterReset();
		fillFrameBuffer(); // before enable, so the first pass is known
		checkPanelReset();
		checkInitOrder();
		checkPixelStream();
		checkLiveUpdate();
		checkWordFraming();
		$display("summary: %0d errors, %0d words received", errorCount, wordsSeen);
		if (errorCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== tft.mem ====
// one {dc, byte} word per line, dc in the top hex digit: 0 command, 1 data
0CB
139
12C
100
134
102
0CF
100
1C1
130
0E8
185
100
178
0EA
100
100
0ED
164
103
112
181
0F7
120
0C0
123
0C1
110
0C5
13E
128
0C7
186
036
148
03A
155
0B1
100
118
0B6
108
182
127
0F2
100
026
101
020
013
029
02C

// ==== vlog.f ====
tftPkg.sv
tftInitRom.sv
tftSpiSerializer.sv
tftFrameBuffer.sv
tftConfigRegs.sv
tftController.sv
tftSubsystem.sv
tftClockGen.sv
tbTftSubsystem.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the tft subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tbTftSubsystem -f vlog.f -o simTft
./obj_dir/simTft > sim.log 2>&1
cat sim.log

if grep -q "TEST PASS" sim.log; then
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
